// ==== lc3b_types_pkg.sv ====
`default_nettype none

package lc3b_types_pkg;

    typedef logic [15:0] lc3b_word;

    typedef logic [2:0] lc3b_cc;                // Bit order n z p.

    // Opcode values follow the LC-3b encoding.
    typedef enum logic [3:0] {
        BR   = 4'b0000,
        ADD  = 4'b0001,
        LDB  = 4'b0010,
        STB  = 4'b0011,
        LDR  = 4'b0110,
        STR  = 4'b0111,
        LDI  = 4'b1010,
        STI  = 4'b1011,
        TRAP = 4'b1111
    } lc3b_opcode;

    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] nzp;                        // Branch condition mask.
        logic [8:0] pcoffset9;
    } lc3b_instr_br;

    typedef struct packed {
        lc3b_opcode opcode;
        logic [3:0] unused;
        logic [7:0] trapvect8;                  // Trap table index.
    } lc3b_instr_trap;

    typedef union packed {
        lc3b_instr_br   br;
        lc3b_instr_trap trap;
    } lc3b_instr;

    typedef struct packed {
        logic [1:0] cc_gen_mux_sel;             // pcn alu mdr sr2.
        logic       cc_load;
        logic       br_en_load;
        logic       data_memory_access;
        logic       data_memory_write;
        logic       data_memory_word_align;     // Word when set, byte otherwise.
        logic       data_memory_indirect;       // LDI and STI.
        logic [1:0] regfile_data_mux_sel;       // pc pcn zero alu.
    } lc3b_control_word;

    // Data address sources.
    localparam logic [1:0] ADDR_SEL_TRAP = 2'd0;
    localparam logic [1:0] ADDR_SEL_ALU  = 2'd1;
    localparam logic [1:0] ADDR_SEL_MDR  = 2'd2;

endpackage

`default_nettype wire

// ==== lc3b_bus_pkg.sv ====
`default_nettype none

package lc3b_bus_pkg;

    typedef logic [11:0]  line_addr;            // Address bits 15:4.
    typedef logic [127:0] line_data;
    typedef logic [15:0]  line_sel;             // One bit per byte lane.

    // Master side of the line bus.
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        line_addr adr;
        line_sel  sel;
        line_data dat_m;
    } bus_req;

    // Slave side of the line bus.
    typedef struct packed {
        logic     ack;                          // One cycle pulse.
        line_data dat_s;                        // Valid with ack.
    } bus_rsp;

endpackage

`default_nettype wire

// ==== mem_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wait_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [3:0] latency,
    output logic       done
);

    logic [3:0] count;
    logic       running;                        // Count holds a live countdown.
    logic       reload;                         // Gap cycle after done.
    logic [3:0] cur;

    // A fresh access sees latency-1 directly.
    assign cur  = running ? count : latency - 4'd1;
    assign done = start && !reload && (cur == 4'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= 4'd0;
            running <= 1'b0;
            reload  <= 1'b0;
        end else if (!start) begin
            running <= 1'b0;                    // Request dropped.
            reload  <= 1'b0;
        end else if (reload) begin
            reload  <= 1'b0;                    // Next cycle restarts.
        end else if (done) begin
            running <= 1'b0;
            reload  <= 1'b1;
        end else begin
            count   <= cur - 4'd1;
            running <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== data_line_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_line_ram #(
    parameter int MEM_LINES   = 16,
    parameter int MEM_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_bus_pkg::bus_req req,
    output lc3b_bus_pkg::bus_rsp rsp
);

    localparam int IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

    lc3b_bus_pkg::line_data lines [MEM_LINES] = '{default: '0};

    logic [IDX_W-1:0] line_idx;
    logic             access_done;

    // Line address wraps around the array depth.
    assign line_idx = IDX_W'(req.adr % lc3b_bus_pkg::line_addr'(MEM_LINES));

    mem_wait_timer u_wait_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (req.cyc && req.stb),
        .latency (4'(MEM_LATENCY)),
        .done    (access_done)
    );

    always_comb begin
        rsp.ack   = access_done;
        rsp.dat_s = lines[line_idx];            // Whole line for reads.
    end

    // Byte lane writes land on the ack edge.
    always_ff @(posedge clk) begin
        if (access_done && req.we) begin
            for (int b = 0; b < 16; b++) begin
                if (req.sel[b]) begin
                    lines[line_idx][b*8 +: 8] <= req.dat_m[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_access_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_controller (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             stall,
    input  lc3b_types_pkg::lc3b_control_word control_in,
    input  lc3b_types_pkg::lc3b_opcode       opcode,
    input  logic                             ack,
    output logic [1:0]                       addr_sel,
    output logic                             bus_we,
    output logic                             mdr_load,
    output logic                             mem_stall
);

    typedef enum logic [1:0] {
        IDLE,
        POINTER,
        DATA
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        addr_sel   = lc3b_types_pkg::ADDR_SEL_ALU;
        bus_we     = 1'b0;
        mdr_load   = 1'b0;
        mem_stall  = 1'b0;
        state_next = state;
        case (state)
            IDLE: begin
                if (control_in.data_memory_access) begin
                    if (control_in.data_memory_indirect) begin
                        // First cycle of the pointer read.
                        mem_stall  = 1'b1;
                        mdr_load   = ack;
                        state_next = ack ? DATA : POINTER;
                    end else begin
                        if (opcode == lc3b_types_pkg::TRAP) begin
                            addr_sel = lc3b_types_pkg::ADDR_SEL_TRAP;
                        end
                        bus_we    = control_in.data_memory_write;
                        mem_stall = stall || !ack;
                    end
                end
            end
            POINTER: begin
                mem_stall = 1'b1;               // Pointer ack never ends the stall.
                mdr_load  = ack;
                if (ack) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                addr_sel  = lc3b_types_pkg::ADDR_SEL_MDR;
                bus_we    = control_in.data_memory_write;
                mem_stall = stall || !ack;
                if (ack) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (!stall) begin
            state <= state_next;                // Held while the pipeline stalls.
        end
    end

endmodule

`default_nettype wire

// ==== stage_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_mem (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             stall,
    input  lc3b_types_pkg::lc3b_control_word control_in,
    input  lc3b_types_pkg::lc3b_instr        ir_in,
    input  lc3b_types_pkg::lc3b_word         alu_in,
    input  lc3b_types_pkg::lc3b_word         pc_in,
    input  lc3b_types_pkg::lc3b_word         pcn_in,
    input  lc3b_types_pkg::lc3b_word         sr2_in,
    input  lc3b_bus_pkg::bus_rsp             rsp,
    output lc3b_bus_pkg::bus_req             req,
    output logic                             br_en,
    output lc3b_types_pkg::lc3b_word         mdr,
    output lc3b_types_pkg::lc3b_word         regfile_data,
    output logic                             mem_stall
);

    lc3b_types_pkg::lc3b_word cc_src;
    lc3b_types_pkg::lc3b_cc   cc_gen;
    lc3b_types_pkg::lc3b_cc   cc;
    lc3b_types_pkg::lc3b_word internal_mdr;
    lc3b_types_pkg::lc3b_word trap_addr;
    lc3b_types_pkg::lc3b_word data_addr;
    logic [1:0]               addr_sel;
    logic [2:0]               lane;
    logic                     bus_we;
    logic                     mdr_load;
    logic                     instr_done;

    assign instr_done = !stall && !mem_stall;   // Edge that retires the instruction.

    always_comb begin
        case (control_in.cc_gen_mux_sel)
            2'd0:    cc_src = pcn_in;
            2'd1:    cc_src = alu_in;
            2'd2:    cc_src = mdr;
            default: cc_src = sr2_in;
        endcase
    end

    assign cc_gen = {cc_src[15], cc_src == 16'h0000, !cc_src[15] && (cc_src != 16'h0000)};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc           <= '0;
            br_en        <= 1'b0;
            internal_mdr <= '0;
        end else begin
            if (instr_done && control_in.cc_load) begin
                cc <= cc_gen;
            end
            if (instr_done && control_in.br_en_load) begin
                br_en <= |(cc & ir_in.br.nzp);  // Stored cc against nzp.
            end
            if (!stall && mdr_load) begin
                internal_mdr <= mdr;            // Pointer for LDI and STI.
            end
        end
    end

    mem_access_controller u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .control_in (control_in),
        .opcode     (ir_in.br.opcode),
        .ack        (rsp.ack),
        .addr_sel   (addr_sel),
        .bus_we     (bus_we),
        .mdr_load   (mdr_load),
        .mem_stall  (mem_stall)
    );

    assign trap_addr = {7'b0000000, ir_in.trap.trapvect8, 1'b0};

    always_comb begin
        case (addr_sel)
            lc3b_types_pkg::ADDR_SEL_TRAP: data_addr = trap_addr;
            lc3b_types_pkg::ADDR_SEL_MDR:  data_addr = internal_mdr;
            default:                       data_addr = alu_in;
        endcase
    end

    assign lane = data_addr[3:1];

    always_comb begin
        req     = '0;
        req.cyc = control_in.data_memory_access;
        req.stb = control_in.data_memory_access;
        req.we  = bus_we;
        req.adr = data_addr[15:4];
        if (control_in.data_memory_word_align) begin
            req.dat_m[lane*16 +: 16] = sr2_in;
            if (control_in.data_memory_access) begin
                req.sel[lane*2 +: 2] = 2'b11;
            end
        end else begin
            req.dat_m[data_addr[3:0]*8 +: 8] = sr2_in[7:0];
            if (control_in.data_memory_access) begin
                req.sel[data_addr[3:0]] = 1'b1; // Odd address is the high byte.
            end
        end
    end

    always_comb begin
        if (control_in.data_memory_word_align) begin
            mdr = rsp.dat_s[lane*16 +: 16];
        end else begin
            mdr = {8'h00, rsp.dat_s[data_addr[3:0]*8 +: 8]};
        end
    end

    // Forwarding value without the load result.
    always_comb begin
        case (control_in.regfile_data_mux_sel)
            2'd0:    regfile_data = pc_in;
            2'd1:    regfile_data = pcn_in;
            2'd2:    regfile_data = 16'h0000;
            default: regfile_data = alu_in;
        endcase
    end

endmodule

`default_nettype wire

// ==== lc3b_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_mem_top #(
    parameter int MEM_LINES   = 16,
    parameter int MEM_LATENCY = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             stall,
    input  lc3b_types_pkg::lc3b_control_word control_in,
    input  lc3b_types_pkg::lc3b_instr        ir_in,
    input  lc3b_types_pkg::lc3b_word         alu_in,
    input  lc3b_types_pkg::lc3b_word         pc_in,
    input  lc3b_types_pkg::lc3b_word         pcn_in,
    input  lc3b_types_pkg::lc3b_word         sr2_in,
    output logic                             br_en,
    output lc3b_types_pkg::lc3b_word         mdr,
    output lc3b_types_pkg::lc3b_word         regfile_data,
    output logic                             mem_stall
);

    lc3b_bus_pkg::bus_req req;
    lc3b_bus_pkg::bus_rsp rsp;

    stage_mem u_stage_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .control_in   (control_in),
        .ir_in        (ir_in),
        .alu_in       (alu_in),
        .pc_in        (pc_in),
        .pcn_in       (pcn_in),
        .sr2_in       (sr2_in),
        .rsp          (rsp),
        .req          (req),
        .br_en        (br_en),
        .mdr          (mdr),
        .regfile_data (regfile_data),
        .mem_stall    (mem_stall)
    );

    data_line_ram #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

endmodule

`default_nettype wire

// ==== lc3b_mem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_mem_assert (
    input logic                 clk,
    input logic                 rst_n,
    input lc3b_bus_pkg::bus_req req,
    input lc3b_bus_pkg::bus_rsp rsp
);

    // An ack only answers an open request.
    ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.ack |-> (req.cyc && req.stb))
        else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.ack && req.cyc) |=> !(rsp.ack && req.cyc))
        else $error("ack held high for two cycles");

    write_controls_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (req.we || (req.sel != '0)) |-> req.cyc)
        else $error("we or sel driven outside a bus cycle");

endmodule

bind data_line_ram lc3b_mem_assert u_bus_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;         // Half period per phase.

endmodule

`default_nettype wire

// ==== tb_lc3b_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_mem;

    localparam int MEM_LINES   = 16;
    localparam int MEM_LATENCY = 3;
    localparam int N_INSTR     = 400;
    localparam int WINDOW      = MEM_LINES * 16;   // Bytes held by the memory.
    localparam int TIMEOUT     = N_INSTR * (2 * MEM_LATENCY + 8) + 100;

    logic                             clk;
    logic                             rst_n;
    logic                             stall;
    lc3b_types_pkg::lc3b_control_word ctrl;
    lc3b_types_pkg::lc3b_instr        ir;
    lc3b_types_pkg::lc3b_word         alu;
    lc3b_types_pkg::lc3b_word         pc;
    lc3b_types_pkg::lc3b_word         pcn;
    lc3b_types_pkg::lc3b_word         sr2;
    logic                             br_en;
    lc3b_types_pkg::lc3b_word         mdr;
    lc3b_types_pkg::lc3b_word         regfile_data;
    logic                             mem_stall;

    // Reference model state.
    logic [7:0]                 model_mem [WINDOW] = '{default: 8'h00};
    lc3b_types_pkg::lc3b_cc     model_cc;
    logic                       model_br;
    logic [15:0]                lfsr;
    int                         cycle_count = 0;
    int                         kind;
    int                         cycles;
    int                         exp_cycles;
    int                         a;
    logic                       stalled;
    logic                       finished;
    logic                       prev_access;
    logic [7:0]                 addr;
    lc3b_types_pkg::lc3b_opcode op;
    lc3b_types_pkg::lc3b_word   final_addr;
    lc3b_types_pkg::lc3b_word   exp_mdr;
    lc3b_types_pkg::lc3b_word   exp_rf;
    lc3b_types_pkg::lc3b_word   cc_src;
    lc3b_types_pkg::lc3b_cc     next_cc;
    logic                       next_br;

    tb_clock_gen #(.PERIOD_NS(8)) u_clock_gen (.clk(clk));

    lc3b_mem_top #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .control_in   (ctrl),
        .ir_in        (ir),
        .alu_in       (alu),
        .pc_in        (pc),
        .pcn_in       (pcn),
        .sr2_in       (sr2),
        .br_en        (br_en),
        .mdr          (mdr),
        .regfile_data (regfile_data),
        .mem_stall    (mem_stall)
    );

    // Fibonacci LFSR, taps 16 14 13 11.
    function automatic logic [15:0] draw_bits(input int nbits);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    // Little endian, word reads ignore address bit 0.
    function automatic lc3b_types_pkg::lc3b_word model_read(input lc3b_types_pkg::lc3b_word ad,
                                                            input logic word);
        int b;
        b = int'(ad) % WINDOW;
        if (word) begin
            return {model_mem[b | 1], model_mem[b & ~1]};
        end
        return {8'h00, model_mem[b]};
    endfunction

    function automatic lc3b_types_pkg::lc3b_cc sign_cc(input lc3b_types_pkg::lc3b_word v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input lc3b_types_pkg::lc3b_word exp,
                              input lc3b_types_pkg::lc3b_word act);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cc(input lc3b_types_pkg::lc3b_cc exp, input lc3b_types_pkg::lc3b_cc act);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] cc expected %h actual %h", exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            fail_run("timeout waiting for mem_stall to fall");
        end
    end

    initial begin
        rst_n       = 1'b0;
        stall       = 1'b0;
        ctrl        = '0;
        ir          = '0;
        alu         = '0;
        pc          = '0;
        pcn         = '0;
        sr2         = '0;
        lfsr        = 16'd27110;
        model_cc    = '0;
        model_br    = 1'b0;
        prev_access = 1'b0;
        addr        = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            kind = int'(draw_bits(3));
            case (kind)
                0:       op = lc3b_types_pkg::LDR;
                1:       op = lc3b_types_pkg::STR;
                2:       op = lc3b_types_pkg::LDB;
                3:       op = lc3b_types_pkg::STB;
                4:       op = lc3b_types_pkg::LDI;
                5:       op = lc3b_types_pkg::STI;
                6:       op = lc3b_types_pkg::TRAP;
                default: op = (draw_bits(1) == 16'd1) ? lc3b_types_pkg::BR : lc3b_types_pkg::ADD;
            endcase
            ctrl.data_memory_access     = (kind != 7);
            ctrl.data_memory_write      = (kind == 1) || (kind == 3) || (kind == 5);
            ctrl.data_memory_word_align = (kind == 7) ? 1'(draw_bits(1)) : !(kind == 2 || kind == 3);
            ctrl.data_memory_indirect   = (kind == 4) || (kind == 5);
            ctrl.cc_gen_mux_sel         = 2'(draw_bits(2));
            ctrl.cc_load                = 1'(draw_bits(1)) && !ctrl.data_memory_write;
            ctrl.br_en_load             = 1'(draw_bits(1));
            ctrl.regfile_data_mux_sel   = 2'(draw_bits(2));
            if (draw_bits(1) != 16'd1) begin
                addr = 8'(draw_bits(8));                // Else reuse the last address.
            end
            if (ctrl.data_memory_word_align) begin
                addr[0] = 1'b0;
            end
            ir  = {op, 12'(draw_bits(12))};
            alu = {8'h00, addr};
            pc  = draw_bits(16);
            pcn = draw_bits(16);
            sr2 = draw_bits(16);

            // Expected results from the current model state.
            if (kind == 6) begin
                final_addr = 16'(ir.trap.trapvect8) * 16'd2;
            end else if (ctrl.data_memory_indirect) begin
                final_addr = model_read(alu, 1'b1);     // Pointer word.
            end else begin
                final_addr = alu;
            end
            exp_mdr = model_read(final_addr, ctrl.data_memory_word_align);
            case (ctrl.regfile_data_mux_sel)
                2'd0:    exp_rf = pc;
                2'd1:    exp_rf = pcn;
                2'd2:    exp_rf = 16'h0000;
                default: exp_rf = alu;
            endcase
            case (ctrl.cc_gen_mux_sel)
                2'd0:    cc_src = pcn;
                2'd1:    cc_src = alu;
                2'd2:    cc_src = exp_mdr;
                default: cc_src = sr2;
            endcase
            next_br = ctrl.br_en_load ? |(model_cc & ir.br.nzp) : model_br;
            next_cc = ctrl.cc_load ? sign_cc(cc_src) : model_cc;
            if (!ctrl.data_memory_access) begin
                exp_cycles = 1;
            end else begin
                exp_cycles = ctrl.data_memory_indirect ? 2 * MEM_LATENCY + 1 : MEM_LATENCY;
                exp_cycles += prev_access ? 1 : 0;      // Timer gap after the last ack.
            end

            stall    = (draw_bits(2) == 16'd3);
            cycles   = 0;
            stalled  = 1'b0;
            finished = 1'b0;
            while (!finished) begin
                @(negedge clk);
                stalled = stalled || stall;
                check_flag("br_en", model_br, br_en);
                if (!ctrl.data_memory_access) begin
                    check_flag("mem_stall", 1'b0, mem_stall);
                end
                if (!mem_stall && !stall) begin
                    finished = 1'b1;
                    check_word("regfile_data", exp_rf, regfile_data);
                    if (!ctrl.data_memory_write) begin
                        check_word("mdr", exp_mdr, mdr);
                    end
                end
                @(posedge clk);
                cycles++;
                #1;
                if (!finished) begin
                    stall = (draw_bits(2) == 16'd3);
                end
            end

            if (!stalled && cycles != exp_cycles) begin
                fail_run($sformatf("instruction %0d took %0d cycles instead of %0d",
                                   n, cycles, exp_cycles));
            end
            if (ctrl.data_memory_write) begin
                a = int'(final_addr) % WINDOW;
                if (ctrl.data_memory_word_align) begin
                    model_mem[a & ~1] = sr2[7:0];
                    model_mem[a | 1]  = sr2[15:8];
                end else begin
                    model_mem[a] = sr2[7:0];
                end
            end
            model_br    = next_br;
            model_cc    = next_cc;
            prev_access = ctrl.data_memory_access;
            check_flag("br_en", model_br, br_en);
            check_cc(model_cc, UUT.u_stage_mem.cc);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
lc3b_types_pkg.sv
lc3b_bus_pkg.sv
mem_wait_timer.sv
data_line_ram.sv
mem_access_controller.sv
stage_mem.sv
lc3b_mem_top.sv
lc3b_mem_assert.sv
tb_clock_gen.sv
tb_lc3b_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the LC-3b memory stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_lc3b_mem -f list.f \
    --Mdir obj_dir -o tb_lc3b_mem
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_lc3b_mem
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
